// File: sim/route_vectors.txt
# line 3: the 11 hcm entries in 3.13 hex, entry 0 first
# then per test: name count battery(hex) expected_index expected_result(hex) q-values(hex)
2000 2400 2800 2C00 3000 3400 3800 3C00 4000 4800 6000
one_neighbor 1 0000 0 0100
0100
five_min_last 5 3000 4 0300
0800 0400 0900 0500 0200
sixteen_busy 16 6666 8 0600
1000 0F00 0E00 0D00 0C00 0B00 0A00 0900
0300 0800 0700 0600 0500 0400 0340 0380
clamp_full 3 FFFF 10 0C60
0440 0420 0460
round_up 2 1999 2 0A00
0800 0900
zero_neighbors 0 0000 0 FFFE
exact_top 4 8000 10 0300
1000 0100 0100 2000

// File: project.f
source/route_pkg.sv
source/node_memory.sv
source/apb_node_regs.sv
source/neighbor_scan.sv
source/hcm_scale.sv
source/route_sequencer.sv
source/route_node_top.sv
sim/route_node_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the route node testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -f project.f --top-module route_node_tb -o route_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator compile failed with status $status"
	exit 1
fi

./obj_dir/route_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "\*\*\* TEST PASSED \*\*\*" sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed, see sim.log"
	exit 1
fi

// File: sim/route_node_tb.sv
`timescale 1ns/1ps

module route_node_tb;

	localparam int max_tests = 16;
	localparam int max_nb = 16;
	localparam int clk_period = 20;
	localparam int xfer_cycles = 6;  // worst case cycles per apb transfer incl. gap

	logic clock;
	logic nrst;
	logic psel;
	logic penable;
	logic pwrite;
	logic [route_pkg::apb_addr_w-1:0] paddr;
	route_pkg::word_t pwdata;
	route_pkg::word_t prdata;
	logic pready;
	logic pslverr;

	route_pkg::word_t hcm [route_pkg::hcm_length];
	logic [255:0] names [max_tests];
	int counts [max_tests];
	route_pkg::word_t batteries [max_tests];
	int exp_idx [max_tests];
	route_pkg::word_t exp_res [max_tests];
	route_pkg::word_t qv [max_tests][max_nb];

	int ntests;
	int max_count;
	int errors;
	int checks;
	int watchdog_cycles;
	int gap_max;
	route_pkg::word_t last_result;

	route_node_top dut (
		.clock(clock), .nrst(nrst),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr)
	);

	initial begin
		clock = 1'b0;
		forever begin
			#(clk_period / 2) clock = ~clock;
		end
	end

	// setup cycle, access cycle, sample just before the access edge
	task automatic apb_transfer(input logic wr, input logic [7:0] addr, input route_pkg::word_t data,
			output route_pkg::word_t rdat, output logic err);
		int gap;
		gap = (gap_max > 0) ? int'($urandom % (gap_max + 1)) : 0;
		repeat (gap) @(posedge clock);
		@(posedge clock);
		#2;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = wr;
		paddr = addr;
		pwdata = data;
		@(posedge clock);
		#2;
		penable = 1'b1;
		#(clk_period - 4);
		rdat = prdata;
		err = pslverr;
		checks++;
		if (pready !== 1'b1) begin
			errors++;
			$display("pready was not high in the access phase at offset %h", addr);
		end
		@(posedge clock);
		#2;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apb_write(input logic [7:0] addr, input route_pkg::word_t data, output logic err);
		route_pkg::word_t unused;
		apb_transfer(1'b1, addr, data, unused, err);
	endtask

	task automatic apb_read(input logic [7:0] addr, output route_pkg::word_t data, output logic err);
		apb_transfer(1'b0, addr, 16'h0000, data, err);
	endtask

	task automatic check_word(input string test, input string what, input route_pkg::word_t exp,
			input route_pkg::word_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("error %0s %0s expected %h actual %h", test, what, exp, act);
		end
	endtask

	// ceiling of 10 * battery in 1.15, clamped to the last entry
	function automatic int hcm_index(input route_pkg::word_t bat);
		logic [31:0] k;
		int i;
		k = 32'(bat) * 32'd10;
		i = int'(k >> 15);
		if (k[14:0] != 15'd0) begin
			i = i + 1;
		end
		if (i > route_pkg::hcm_length - 1) begin
			i = route_pkg::hcm_length - 1;
		end
		return i;
	endfunction

	// 11.5 times 3.13, back to 11.5
	function automatic route_pkg::word_t scale_q(input route_pkg::word_t q, input route_pkg::word_t h);
		logic [31:0] p;
		p = 32'(q) * 32'(h);
		return p[28:13];
	endfunction

	task automatic read_vectors();
		int fd;
		int r;
		string line;
		ntests = 0;
		max_count = 0;
		fd = $fopen("sim/route_vectors.txt", "r");
		if (fd == 0) begin
			$display("could not open the vector file sim/route_vectors.txt");
			errors++;
		end else begin
			r = $fgets(line, fd);  // two column description lines
			r = $fgets(line, fd);
			for (int i = 0; i < route_pkg::hcm_length; i++) begin
				r = $fscanf(fd, "%h", hcm[i]);
			end
			while (ntests < max_tests) begin
				r = $fscanf(fd, "%s %d %h %d %h", names[ntests], counts[ntests],
					batteries[ntests], exp_idx[ntests], exp_res[ntests]);
				if (r != 5) break;
				if (counts[ntests] > max_nb) begin
					$display("vector %0d has more neighbors than the testbench holds", ntests);
					errors++;
					counts[ntests] = max_nb;
				end
				for (int j = 0; j < counts[ntests]; j++) begin
					r = $fscanf(fd, "%h", qv[ntests][j]);
				end
				if (counts[ntests] > max_count) max_count = counts[ntests];
				ntests++;
			end
			$fclose(fd);
		end
	endtask

	task automatic run_test(input int t);
		string tname;
		route_pkg::word_t best;
		route_pkg::word_t rd;
		logic err;
		int idx;
		tname = $sformatf("%0s", names[t]);

		// the vector's own expectation must follow the index and scaling rules
		best = route_pkg::best_init;
		for (int j = 0; j < counts[t]; j++) begin
			if (qv[t][j] < best) best = qv[t][j];
		end
		idx = hcm_index(batteries[t]);
		check_word(tname, "vector index", 16'(exp_idx[t]), 16'(idx));
		check_word(tname, "vector result", exp_res[t], scale_q(best, hcm[idx]));

		apb_write(route_pkg::reg_mem_addr, 16'(route_pkg::neighbor_count_addr), err);
		apb_write(route_pkg::reg_mem_data, 16'(counts[t]), err);
		apb_write(route_pkg::reg_mem_addr, 16'(route_pkg::qvalue_base), err);
		for (int j = 0; j < counts[t]; j++) begin
			apb_write(route_pkg::reg_mem_data, qv[t][j], err);
		end
		apb_write(route_pkg::reg_battery, batteries[t], err);
		apb_read(route_pkg::reg_battery, rd, err);
		check_word(tname, "battery readback", batteries[t], rd);

		apb_write(route_pkg::reg_ctrl, 16'h0001, err);
		check_word(tname, "start pslverr", 16'h0000, 16'(err));
		gap_max = 0;  // keep the busy window tight
		apb_read(route_pkg::reg_status, rd, err);
		check_word(tname, "status after start", 16'h0002, rd);  // busy, done cleared
		if (counts[t] == max_nb) begin
			apb_write(route_pkg::reg_mem_data, 16'h0001, err);
			check_word(tname, "mem_data while busy pslverr", 16'h0001, 16'(err));
			apb_write(route_pkg::reg_battery, 16'h1234, err);
			check_word(tname, "battery while busy pslverr", 16'h0001, 16'(err));
			apb_write(route_pkg::reg_ctrl, 16'h0001, err);
			check_word(tname, "start while busy pslverr", 16'h0001, 16'(err));
			apb_read(route_pkg::reg_result, rd, err);
			check_word(tname, "result while busy", last_result, rd);
		end
		gap_max = 3;

		rd = 16'h0000;
		while (rd[0] !== 1'b1) begin
			apb_read(route_pkg::reg_status, rd, err);
		end
		check_word(tname, "status at done", 16'h0001, rd);
		apb_read(route_pkg::reg_result, rd, err);
		check_word(tname, "result", exp_res[t], rd);
		last_result = exp_res[t];
		apb_read(route_pkg::reg_battery, rd, err);
		check_word(tname, "battery after run", batteries[t], rd);
	endtask

	// watchdog sized from the vector file once it is read
	initial begin
		wait (watchdog_cycles > 0);
		repeat (watchdog_cycles) @(posedge clock);
		$display("timeout: the run did not finish within %0d cycles", watchdog_cycles);
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin
		route_pkg::word_t rd;
		logic err;
		nrst = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		errors = 0;
		checks = 0;
		watchdog_cycles = 0;
		gap_max = 3;
		void'($urandom(35));

		read_vectors();
		watchdog_cycles = (ntests + 1) * (max_count + 60) * xfer_cycles;

		repeat (8) @(posedge clock);
		#2;
		nrst = 1'b1;

		apb_read(route_pkg::reg_status, rd, err);
		check_word("reset", "status", 16'h0000, rd);
		apb_read(route_pkg::reg_result, rd, err);
		check_word("reset", "result", route_pkg::best_init, rd);
		last_result = route_pkg::best_init;
		apb_read(8'h20, rd, err);
		check_word("unmapped", "read pslverr", 16'h0001, 16'(err));
		apb_write(8'h3C, 16'h5555, err);
		check_word("unmapped", "write pslverr", 16'h0001, 16'(err));

		apb_write(route_pkg::reg_mem_addr, 16'(route_pkg::hcm_base), err);
		for (int i = 0; i < route_pkg::hcm_length; i++) begin
			apb_write(route_pkg::reg_mem_data, hcm[i], err);
		end

		for (int t = 0; t < ntests; t++) begin
			run_test(t);
		end

		$display("tests %0d checks %0d errors %0d", ntests, checks, errors);
		if (errors == 0 && ntests > 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// File: source/route_node_top.sv
`timescale 1ns/1ps

module route_node_top (
	input  logic                             clock,
	input  logic                             nrst,
	input  logic                             psel,
	input  logic                             penable,
	input  logic                             pwrite,
	input  logic [route_pkg::apb_addr_w-1:0] paddr,
	input  route_pkg::word_t                 pwdata,
	output route_pkg::word_t                 prdata,
	output logic                             pready,
	output logic                             pslverr
);

	logic busy;
	logic done;
	logic start;
	logic mem_we;
	logic scan_start;
	logic scan_done;
	logic scale_start;
	logic scale_done;
	route_pkg::word_t result;
	route_pkg::word_t battery;
	route_pkg::word_t mem_wdata;
	route_pkg::word_t rdata;
	route_pkg::word_t best_q;
	route_pkg::word_t scaled;
	route_pkg::addr_t mem_waddr;
	route_pkg::addr_t rd_addr;
	route_pkg::addr_t scan_addr;
	route_pkg::addr_t hcm_addr;

	apb_node_regs u_regs (
		.clock(clock), .nrst(nrst),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.busy(busy), .done(done), .result(result), .battery(battery), .start(start),
		.mem_we(mem_we), .mem_waddr(mem_waddr), .mem_wdata(mem_wdata)
	);

	node_memory u_mem (
		.clock(clock), .nrst(nrst),
		.mem_we(mem_we), .mem_waddr(mem_waddr), .mem_wdata(mem_wdata),
		.rd_addr(rd_addr), .rdata(rdata)
	);

	neighbor_scan u_scan (
		.clock(clock), .nrst(nrst), .scan_start(scan_start), .rdata(rdata),
		.scan_addr(scan_addr), .best_q(best_q), .scan_done(scan_done)
	);

	hcm_scale u_scale (
		.clock(clock), .nrst(nrst), .scale_start(scale_start),
		.best_q(best_q), .battery(battery), .rdata(rdata),
		.hcm_addr(hcm_addr), .scaled(scaled), .scale_done(scale_done)
	);

	route_sequencer u_seq (
		.clock(clock), .nrst(nrst), .start(start),
		.scan_addr(scan_addr), .hcm_addr(hcm_addr),
		.scan_done(scan_done), .scale_done(scale_done), .scaled(scaled),
		.rd_addr(rd_addr), .scan_start(scan_start), .scale_start(scale_start),
		.busy(busy), .done(done), .result(result)
	);

endmodule

// File: source/route_sequencer.sv
`timescale 1ns/1ps

module route_sequencer (
	input  logic             clock,
	input  logic             nrst,
	input  logic             start,
	input  route_pkg::addr_t scan_addr,
	input  route_pkg::addr_t hcm_addr,
	input  logic             scan_done,
	input  logic             scale_done,
	input  route_pkg::word_t scaled,
	output route_pkg::addr_t rd_addr,
	output logic             scan_start,
	output logic             scale_start,
	output logic             busy,
	output logic             done,
	output route_pkg::word_t result
);

	route_pkg::seq_state_t state;

	assign busy = (state == route_pkg::scanning) || (state == route_pkg::scaling);

	// hcm fetch owns the read port only while scaling
	assign rd_addr = (state == route_pkg::scaling) ? hcm_addr : scan_addr;

	always_ff @(posedge clock) begin
		if (!nrst) begin
			state <= route_pkg::idle;
			scan_start <= 1'b0;
			scale_start <= 1'b0;
			done <= 1'b0;
			result <= route_pkg::best_init;
		end else begin
			scan_start <= 1'b0;
			scale_start <= 1'b0;
			case (state)
				route_pkg::idle, route_pkg::finished: begin
					if (start) begin
						state <= route_pkg::scanning;
						scan_start <= 1'b1;
						done <= 1'b0;  // cleared by the next start
					end
				end
				route_pkg::scanning: begin
					if (scan_done) begin
						state <= route_pkg::scaling;
						scale_start <= 1'b1;
					end
				end
				route_pkg::scaling: begin
					if (scale_done) begin
						state <= route_pkg::finished;
						result <= scaled;
						done <= 1'b1;  // busy drops with it
					end
				end
				default: state <= route_pkg::idle;
			endcase
		end
	end

endmodule

// File: source/hcm_scale.sv
`timescale 1ns/1ps

module hcm_scale (
	input  logic             clock,
	input  logic             nrst,
	input  logic             scale_start,
	input  route_pkg::word_t best_q,
	input  route_pkg::word_t battery,
	input  route_pkg::word_t rdata,
	output route_pkg::addr_t hcm_addr,
	output route_pkg::word_t scaled,
	output logic             scale_done
);

	localparam route_pkg::word_t max_index = route_pkg::word_t'(route_pkg::hcm_length - 1);

	logic [3:0] stage;  // one bit per pipeline step
	route_pkg::prod_t battery_prod;
	route_pkg::prod_t k_prod;
	route_pkg::prod_t best_prod;
	route_pkg::word_t index;
	route_pkg::word_t index_clamped;

	// 16.0 times 1.15 gives 17.15
	assign battery_prod = route_pkg::prod_t'(max_index) * route_pkg::prod_t'(battery);
	assign index_clamped = (index > max_index) ? max_index : index;
	// 11.5 times 3.13 gives 14.18
	assign best_prod = route_pkg::prod_t'(best_q) * route_pkg::prod_t'(rdata);

	always_ff @(posedge clock) begin
		if (!nrst) begin
			stage <= '0;
			scale_done <= 1'b0;
		end else begin
			stage <= {stage[2:0], scale_start};
			scale_done <= stage[3];
		end
	end

	always_ff @(posedge clock) begin
		if (scale_start) begin
			k_prod <= battery_prod;
		end
		if (stage[0]) begin
			// ceiling of the scaled battery
			index <= k_prod[route_pkg::battery_frac +: route_pkg::word_w]
				+ route_pkg::word_t'(|k_prod[route_pkg::battery_frac-1:0]);
		end
		if (stage[1]) begin
			hcm_addr <= route_pkg::hcm_base + route_pkg::addr_t'(index_clamped << 1);
		end
		if (stage[3]) begin
			scaled <= best_prod[route_pkg::frac_shift +: route_pkg::word_w];  // back to 11.5
		end
	end

endmodule

// File: source/neighbor_scan.sv
`timescale 1ns/1ps

module neighbor_scan (
	input  logic             clock,
	input  logic             nrst,
	input  logic             scan_start,
	input  route_pkg::word_t rdata,
	output route_pkg::addr_t scan_addr,
	output route_pkg::word_t best_q,
	output logic             scan_done
);

	typedef enum logic [1:0] {
		scan_idle,
		scan_wait,
		scan_count,
		scan_q
	} scan_phase_t;

	scan_phase_t phase;
	route_pkg::word_t count;
	route_pkg::word_t idx;  // index of the q-value now in rdata
	logic last;

	assign last = (idx == count - route_pkg::word_t'(1));

	always_ff @(posedge clock) begin
		if (!nrst) begin
			phase <= scan_idle;
			scan_addr <= route_pkg::neighbor_count_addr;
			best_q <= route_pkg::best_init;
			count <= '0;
			idx <= '0;
			scan_done <= 1'b0;
		end else begin
			scan_done <= 1'b0;
			case (phase)
				scan_idle: begin
					if (scan_start) begin
						scan_addr <= route_pkg::neighbor_count_addr;
						best_q <= route_pkg::best_init;
						phase <= scan_wait;
					end
				end
				scan_wait: begin
					scan_addr <= route_pkg::qvalue_base;  // count word in flight
					phase <= scan_count;
				end
				scan_count: begin
					count <= rdata;
					idx <= '0;
					scan_addr <= scan_addr + route_pkg::addr_t'(2);
					if (rdata == '0) begin
						scan_done <= 1'b1;  // no neighbors, keep best_init
						phase <= scan_idle;
					end else begin
						phase <= scan_q;
					end
				end
				scan_q: begin
					if (rdata < best_q) begin
						best_q <= rdata;  // strictly smaller only
					end
					idx <= idx + route_pkg::word_t'(1);
					scan_addr <= scan_addr + route_pkg::addr_t'(2);  // read runs one ahead
					if (last) begin
						scan_done <= 1'b1;
						phase <= scan_idle;
					end
				end
				default: phase <= scan_idle;
			endcase
		end
	end

endmodule

// File: source/apb_node_regs.sv
`timescale 1ns/1ps

module apb_node_regs (
	input  logic                           clock,
	input  logic                           nrst,
	input  logic                           psel,
	input  logic                           penable,
	input  logic                           pwrite,
	input  logic [route_pkg::apb_addr_w-1:0] paddr,
	input  route_pkg::word_t               pwdata,
	output route_pkg::word_t               prdata,
	output logic                           pready,
	output logic                           pslverr,
	input  logic                           busy,
	input  logic                           done,
	input  route_pkg::word_t               result,
	output route_pkg::word_t               battery,
	output logic                           start,
	output logic                           mem_we,
	output route_pkg::addr_t               mem_waddr,
	output route_pkg::word_t               mem_wdata
);

	logic access;
	logic mapped;
	logic err;
	logic write_ok;
	route_pkg::addr_t load_addr;

	assign access = psel & penable;  // access phase, completes this cycle
	assign write_ok = access & pwrite & ~err;
	assign pready = 1'b1;
	assign pslverr = access & err;

	// read mux and offset decode
	always_comb begin
		mapped = 1'b1;
		case (paddr)
			route_pkg::reg_ctrl: prdata = '0;
			route_pkg::reg_battery: prdata = battery;
			route_pkg::reg_status: prdata = {{(route_pkg::word_w-2){1'b0}}, busy, done};
			route_pkg::reg_result: prdata = result;
			route_pkg::reg_mem_addr: begin
				prdata = {{(route_pkg::word_w-route_pkg::addr_w){1'b0}}, load_addr};
			end
			route_pkg::reg_mem_data: prdata = '0;  // no readback
			default: begin
				prdata = '0;
				mapped = 1'b0;
			end
		endcase
	end

	// writes that would disturb a running search are refused
	always_comb begin
		err = ~mapped;
		if (mapped && pwrite && busy) begin
			case (paddr)
				route_pkg::reg_ctrl: err = pwdata[0];  // start while busy
				route_pkg::reg_battery: err = 1'b1;
				route_pkg::reg_mem_data: err = 1'b1;
				default: err = 1'b0;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (!nrst) begin
			battery <= '0;
			load_addr <= '0;
			start <= 1'b0;
			mem_we <= 1'b0;
		end else begin
			start <= 1'b0;  // single cycle pulse
			mem_we <= 1'b0;
			if (write_ok) begin
				case (paddr)
					route_pkg::reg_ctrl: start <= pwdata[0];
					route_pkg::reg_battery: battery <= pwdata;
					route_pkg::reg_mem_addr: load_addr <= route_pkg::addr_t'(pwdata);
					route_pkg::reg_mem_data: begin
						mem_we <= 1'b1;
						load_addr <= load_addr + route_pkg::addr_t'(2);  // next word
					end
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clock) begin
		if (write_ok && paddr == route_pkg::reg_mem_data) begin
			mem_waddr <= load_addr;
			mem_wdata <= pwdata;
		end
	end

endmodule

// File: source/node_memory.sv
`timescale 1ns/1ps

module node_memory (
	input  logic             clock,
	input  logic             nrst,
	input  logic             mem_we,
	input  route_pkg::addr_t mem_waddr,
	input  route_pkg::word_t mem_wdata,
	input  route_pkg::addr_t rd_addr,
	output route_pkg::word_t rdata
);

	route_pkg::word_t mem [route_pkg::mem_words];

	logic [route_pkg::addr_w-2:0] waddr_word;
	logic [route_pkg::addr_w-2:0] raddr_word;

	assign waddr_word = mem_waddr[route_pkg::addr_w-1:1];  // drop byte bit
	assign raddr_word = rd_addr[route_pkg::addr_w-1:1];

	// load port from the apb window
	always_ff @(posedge clock) begin
		if (mem_we) begin
			mem[waddr_word] <= mem_wdata;
		end
	end

	// one cycle read latency
	always_ff @(posedge clock) begin
		if (!nrst) begin
			rdata <= '0;
		end else begin
			rdata <= mem[raddr_word];
		end
	end

endmodule

// File: source/route_pkg.sv
package route_pkg;

	localparam int word_w = 16;
	localparam int addr_w = 11;
	localparam int apb_addr_w = 8;

	typedef logic [word_w-1:0] word_t;     // q-values, hcm entries, battery, result
	typedef logic [addr_w-1:0] addr_t;     // byte address, bit 0 ignored
	typedef logic [2*word_w-1:0] prod_t;   // full product of two words

	localparam int mem_words = 1024;
	localparam int hcm_length = 11;

	// node memory map, byte addresses
	localparam addr_t neighbor_count_addr = 11'h68A;
	localparam addr_t qvalue_base = 11'h1C8;  // stride 2
	localparam addr_t hcm_base = 11'h648;     // stride 2

	localparam word_t best_init = 16'hFFFE;

	// 14.18 product back to 11.5
	localparam int frac_shift = 13;
	localparam int battery_frac = 15;  // battery status is 1.15

	// apb register offsets
	localparam logic [apb_addr_w-1:0] reg_ctrl = 8'h00;
	localparam logic [apb_addr_w-1:0] reg_battery = 8'h04;
	localparam logic [apb_addr_w-1:0] reg_status = 8'h08;
	localparam logic [apb_addr_w-1:0] reg_result = 8'h0C;
	localparam logic [apb_addr_w-1:0] reg_mem_addr = 8'h10;
	localparam logic [apb_addr_w-1:0] reg_mem_data = 8'h14;

	typedef enum logic [1:0] {
		idle,
		scanning,
		scaling,
		finished
	} seq_state_t;

endpackage
